//--- cache.f
+incdir+.
cache_pkg.sv
set_ram.sv
way_select.sv
line_write.sv
lookup_ctrl.sv
cache_top.sv
cache_tb.sv

//--- cache_cfg.svh
/* geometry macros for the set-associative cache
   ways, sets, word and line sizes, tag and tq id widths */

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ====================
// associativity and depth
// ====================
`define CACHE_NUM_WAYS        4     // ways per set
`define CACHE_NUM_SETS        16    // sets in the tag array

// ====================
// line layout
// ====================
`define CACHE_WORD_W          32    // bits per data word
`define CACHE_WORDS_PER_LINE  4     // words per cache line

// address is {tag, set, byte offset}, upper offset bits pick the word
`define CACHE_TAG_W           8     // tag bits of the 16 bit address

// transaction queue id carried with every request
`define CACHE_TQ_ID_W         4

`endif

//--- cache_pkg.sv
/* cache pipeline types
   geometry localparams, opcode and result enums,
   request / response / pipe bus structs */

`include "cache_cfg.svh"

package cache_pkg;

  // ====================
  // geometry
  // ====================
  localparam int NUM_WAYS       = `CACHE_NUM_WAYS;
  localparam int NUM_SETS       = `CACHE_NUM_SETS;
  localparam int WORD_W         = `CACHE_WORD_W;
  localparam int WORDS_PER_LINE = `CACHE_WORDS_PER_LINE;
  localparam int TAG_W          = `CACHE_TAG_W;
  localparam int TQ_ID_W        = `CACHE_TQ_ID_W;

  localparam int WAY_W      = $clog2(NUM_WAYS);        // encoded way
  localparam int SET_W      = $clog2(NUM_SETS);        // set index
  localparam int WORD_OFF_W = $clog2(WORDS_PER_LINE);  // word within line
  localparam int BYTE_OFF_W = $clog2(WORD_W / 8);      // byte within word
  localparam int OFFSET_W   = WORD_OFF_W + BYTE_OFF_W; // line offset
  localparam int ADDR_W     = TAG_W + SET_W + OFFSET_W;

  // ====================
  // scalar types
  // ====================
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [SET_W-1:0]      set_idx_t;
  typedef logic [OFFSET_W-1:0]   offset_t;
  typedef logic [WORD_OFF_W-1:0] word_off_t;
  typedef logic [NUM_WAYS-1:0]   way_vec_t;  // one bit per way
  typedef logic [WAY_W-1:0]      way_idx_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef word_t [WORDS_PER_LINE-1:0] line_t; // word 0 in the low bits
  typedef logic [TQ_ID_W-1:0]    tq_id_t;

  // data array address, set in the upper bits
  typedef struct packed {
    set_idx_t set;
    way_idx_t way;
  } cl_addr_t;

  typedef enum logic [1:0] {RD_LU, WR_LU, FILL_LU} lu_op_e;
  typedef enum logic [1:0] {NO_RSP, HIT, MISS, FILL} lu_result_e;
  typedef enum logic {FILL_REQ_OP, DIRTY_EVICT_OP} fm_op_e;

  // ====================
  // interface structs
  // ====================
  typedef struct packed {
    logic   valid;
    lu_op_e op;
    tq_id_t tq_id;
    addr_t  address;
    word_t  data;     // write word
    line_t  cl_data;  // fill line
  } lu_req_t;

  // one set of the tag array
  typedef struct packed {
    tag_t [NUM_WAYS-1:0] tags;
    way_vec_t            valid;
    way_vec_t            modified;
    way_vec_t            mru;
  } set_state_t;

  // carried q1 -> q2 -> q3, lookup fields filled in q2
  typedef struct packed {
    logic     valid;
    lu_op_e   op;
    tq_id_t   tq_id;
    tag_t     tag;
    set_idx_t set;
    offset_t  offset;
    word_t    data;
    line_t    cl_data;
    way_vec_t hit_vec;
    logic     hit;
    logic     miss;
    way_vec_t victim_vec;
    way_idx_t victim_way;
    tag_t     victim_tag;   // tag being displaced by a fill
    logic     dirty_evict;
    cl_addr_t cl_addr;
  } pipe_bus_t;

  typedef struct packed {
    way_vec_t   hit_vec;
    way_idx_t   hit_way;
    way_vec_t   victim_vec;
    way_idx_t   victim_way;
    tag_t       victim_tag;
    logic       dirty_evict;
    set_state_t next_set;
  } way_res_t;

  typedef struct packed {
    logic     valid;
    cl_addr_t cl_addr;
    line_t    line;
  } cl_wr_t;

  typedef struct packed {
    logic       valid;
    lu_op_e     op;
    lu_result_e result;
    tq_id_t     tq_id;
    addr_t      address;
    line_t      cl_data;
  } lu_rsp_t;

  typedef struct packed {
    logic   valid;
    fm_op_e opcode;
    addr_t  address;
    tq_id_t tq_id;
    line_t  data;
  } fm_req_t;

endpackage

//--- cache_tb.sv
`timescale 1ns/1ps
/* testbench for cache_top
   clock and reset, galois lfsr stimulus, in-order reference model,
   per-cycle response checks and a watchdog */

module cache_tb;
  import cache_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_REQ     = 600;
  localparam int WATCHDOG_NS = NUM_REQ * 2 * CLK_PERIOD + 20_000;

  logic    clk = 1'b0;
  logic    reset;
  lu_req_t lu_req;
  lu_rsp_t lu_rsp;
  fm_req_t fm_req;

  // ====================
  // dut and clock
  // ====================
  cache_top u_cache_top (.clk, .reset, .lu_req, .lu_rsp, .fm_req);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // reference model state, one entry per set / way
  tag_t     m_tag  [NUM_SETS][NUM_WAYS];
  line_t    m_line [NUM_SETS][NUM_WAYS];
  way_vec_t m_valid [NUM_SETS];
  way_vec_t m_mod   [NUM_SETS];
  way_vec_t m_mru   [NUM_SETS];

  lu_rsp_t  exp_rsp [$];   // expected, oldest first
  fm_req_t  exp_fm  [$];
  logic [15:0] lfsr = 16'd616;
  int rsp_errors = 0;
  int fm_errors  = 0;
  int hit_count  = 0;
  int miss_count = 0;
  int fill_count = 0;
  int evict_count = 0;

  // ====================
  // random bits
  // ====================
  function automatic logic [15:0] galois_step(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) s = s ^ 16'hB400;    // x^16 + x^14 + x^13 + x^11 + 1
    return s;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = galois_step(lfsr);
    end
    return v;
  endfunction

  // ====================
  // reference model
  // ====================
  function automatic int find_way(input set_idx_t s, input tag_t t);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[s][w] && (m_tag[s][w] == t)) return w;
    end
    return -1;                    // line absent
  endfunction

  function automatic int pick_victim(input set_idx_t s);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_valid[s][w]) return w;   // first free way
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_mru[s][w]) return w;     // else first way not mru
    end
    return 0;
  endfunction

  // set the way's mru bit, all set means only this way stays mru
  function automatic way_vec_t touch_mru(input way_vec_t mru, input int w);
    way_vec_t nxt;
    nxt    = mru;
    nxt[w] = 1'b1;
    if (&nxt) nxt = way_vec_t'(1) << w;
    return nxt;
  endfunction

  task automatic model_request(input lu_req_t req, output lu_rsp_t rsp, output fm_req_t fm);
    tag_t     t;
    set_idx_t s;
    int       w;
    int       widx;
    t    = req.address[15:8];     // {tag, set, byte offset}
    s    = req.address[7:4];
    widx = req.address[3:2];
    w    = find_way(s, t);
    rsp  = '0;
    fm   = '0;
    rsp.valid   = 1'b1;
    rsp.op      = req.op;
    rsp.tq_id   = req.tq_id;
    rsp.address = req.address;
    if (req.op == FILL_LU) begin
      w = pick_victim(s);
      if (m_valid[s][w] && m_mod[s][w]) begin   // displaced line goes back out
        fm.valid   = 1'b1;
        fm.opcode  = DIRTY_EVICT_OP;
        fm.address = {m_tag[s][w], s, 4'h0};
        fm.tq_id   = req.tq_id;
        fm.data    = m_line[s][w];
        evict_count++;
      end
      m_tag[s][w]   = t;
      m_line[s][w]  = req.cl_data;
      m_valid[s][w] = 1'b1;
      m_mod[s][w]   = 1'b0;
      m_mru[s]      = touch_mru(m_mru[s], w);
      rsp.result    = FILL;
      rsp.cl_data   = req.cl_data;
      fill_count++;
    end else if (w >= 0) begin
      rsp.result = HIT;
      m_mru[s]   = touch_mru(m_mru[s], w);
      if (req.op == RD_LU) begin
        rsp.cl_data = m_line[s][w];
      end else begin
        m_line[s][w][widx] = req.data;    // only the addressed word
        m_mod[s][w]        = 1'b1;
      end
      hit_count++;
    end else begin
      rsp.result = MISS;
      fm.valid   = 1'b1;
      fm.opcode  = FILL_REQ_OP;
      fm.address = req.address;
      fm.tq_id   = req.tq_id;
      miss_count++;
    end
  endtask

  // ====================
  // checks
  // ====================
  task automatic check_field(input string name, input logic [127:0] exp,
                             input logic [127:0] act, input bit is_fm);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      if (is_fm) fm_errors++;
      else rsp_errors++;
    end
  endtask

  // outputs now belong to the request two cycles back
  task automatic compare_outputs();
    lu_rsp_t r;
    fm_req_t f;
    r = exp_rsp.pop_front();
    f = exp_fm.pop_front();
    check_field("rsp valid", r.valid, lu_rsp.valid, 0);
    if (r.valid) begin
      check_field("rsp tq_id", r.tq_id, lu_rsp.tq_id, 0);
      check_field("rsp op", r.op, lu_rsp.op, 0);
      check_field("rsp address", r.address, lu_rsp.address, 0);
      check_field("rsp result", r.result, lu_rsp.result, 0);
      check_field("rsp cl_data", r.cl_data, lu_rsp.cl_data, 0);
    end
    check_field("fm valid", f.valid, fm_req.valid, 1);
    if (f.valid) begin
      check_field("fm opcode", f.opcode, fm_req.opcode, 1);
      check_field("fm address", f.address, fm_req.address, 1);
      check_field("fm tq_id", f.tq_id, fm_req.tq_id, 1);
      check_field("fm data", f.data, fm_req.data, 1);
    end
  endtask

  // drive after the edge, check at the falling edge
  task automatic run_cycle(input lu_req_t req);
    lu_rsp_t r;
    fm_req_t f;
    @(posedge clk);
    #5;
    lu_req = req;
    r = '0;
    f = '0;
    if (req.valid) model_request(req, r, f);
    exp_rsp.push_back(r);
    exp_fm.push_back(f);
    @(negedge clk);
    compare_outputs();
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    lu_req_t  req;
    tag_t     t;
    set_idx_t s;
    logic [3:0] off;
    int       issued;
    issued = 0;
    reset  = 1'b1;
    lu_req = '0;
    for (int i = 0; i < NUM_SETS; i++) begin
      m_valid[i] = '0;
      m_mod[i]   = '0;
      m_mru[i]   = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[i][w]  = '0;
        m_line[i][w] = '0;
      end
    end
    repeat (2) begin
      @(posedge clk);
      #5;
      if (exp_rsp.size() == 1) reset = 1'b0;   // released after the 2nd edge
      @(negedge clk);
      check_field("reset rsp valid", 1'b0, lu_rsp.valid, 0);
      check_field("reset fm valid", 1'b0, fm_req.valid, 1);
      exp_rsp.push_back('0);    // pipe is empty after reset
      exp_fm.push_back('0);
    end
    while (issued < NUM_REQ) begin
      req = '0;
      if (take_bits(2) != 0) begin              // idle about 1 in 4
        s   = take_bits(1) ? set_idx_t'(12) : set_idx_t'(3);
        t   = 8'h40 + tag_t'(take_bits(3) % 6);   // 6 tags over 4 ways
        off = 4'(take_bits(4));
        req.valid   = 1'b1;
        req.tq_id   = tq_id_t'(issued);
        req.address = {t, s, off};
        if ((find_way(s, t) < 0) && take_bits(1)) begin
          req.op = FILL_LU;                     // fill only an absent line
          for (int k = 0; k < WORDS_PER_LINE; k++) req.cl_data[k] = take_bits(32);
        end else begin
          req.op   = take_bits(1) ? WR_LU : RD_LU;
          req.data = take_bits(32);
        end
        issued++;
      end
      run_cycle(req);
    end
    repeat (2) run_cycle('0);   // drain q2 and q3
    $display("hits %0d misses %0d fills %0d evicts %0d",
             hit_count, miss_count, fill_count, evict_count);
    $display("errors %0d (rsp %0d, fm %0d)", rsp_errors + fm_errors, rsp_errors, fm_errors);
    if (rsp_errors + fm_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // ====================
  // watchdog
  // ====================
  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog expired before all requests were checked");
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- cache_top.sv
`timescale 1ns/1ps
/* cache_top: three stage cache lookup pipeline
   control, way select, line write, tag and data arrays */

`include "cache_cfg.svh"

module cache_top (
  input  logic               clk,
  input  logic               reset,
  input  cache_pkg::lu_req_t lu_req,
  output cache_pkg::lu_rsp_t lu_rsp,
  output cache_pkg::fm_req_t fm_req
);
  import cache_pkg::*;

  // ==================== set path
  set_idx_t   set_rd_addr;
  set_state_t set_rd;
  set_state_t set_q2;
  logic       set_wr_en;
  set_idx_t   set_wr_addr;
  set_state_t set_wr;
  pipe_bus_t  lu_q2;
  way_res_t   res;

  // ==================== data path
  cl_addr_t   cl_rd_addr;
  line_t      ram_line;
  line_t      line_q3;
  pipe_bus_t  lu_q3;
  cl_wr_t     cl_wr;

  lookup_ctrl u_lookup_ctrl (
    .clk, .reset, .lu_req, .set_rd_addr, .set_rd, .lu_q2, .set_q2, .res,
    .set_wr_en, .set_wr_addr, .set_wr, .cl_rd_addr, .lu_q3, .line_q3,
    .lu_rsp, .fm_req
  );

  way_select u_way_select (.lu(lu_q2), .set_in(set_q2), .res);

  line_write u_line_write (.clk, .reset, .lu_q3, .ram_line, .line_q3, .cl_wr);

  set_ram #(.entry_t(set_state_t), .DEPTH(`CACHE_NUM_SETS)) tag_ram (
    .clk, .reset, .rd_addr(set_rd_addr), .rd_data(set_rd),
    .wr_en(set_wr_en), .wr_addr(set_wr_addr), .wr_data(set_wr)
  );

  set_ram #(.entry_t(line_t), .DEPTH(`CACHE_NUM_SETS * `CACHE_NUM_WAYS)) data_ram (
    .clk, .reset, .rd_addr(cl_rd_addr), .rd_data(ram_line),
    .wr_en(cl_wr.valid), .wr_addr(cl_wr.cl_addr), .wr_data(cl_wr.line)
  );

endmodule

//--- line_write.sv
`timescale 1ns/1ps
/* line_write: q3 line forwarding from q4, write word merge,
   data array write request and the q4 write register */

module line_write (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::pipe_bus_t lu_q3,
  input  cache_pkg::line_t     ram_line,  // data array read, q3
  output cache_pkg::line_t     line_q3,   // line after forwarding
  output cache_pkg::cl_wr_t    cl_wr
);
  import cache_pkg::*;

  cl_wr_t    cl_wr_q4;   // last write, not yet visible in the ram read
  line_t     merged;
  word_off_t word_sel;
  logic      fwd_q4;

  // ====================
  // q4 -> q3 forwarding
  // ====================
  assign fwd_q4  = cl_wr_q4.valid && (cl_wr_q4.cl_addr == lu_q3.cl_addr);
  assign line_q3 = fwd_q4 ? cl_wr_q4.line : ram_line;

  // write hit replaces one word
  assign word_sel = lu_q3.offset[OFFSET_W-1 -: WORD_OFF_W];

  always_comb begin
    merged           = line_q3;
    merged[word_sel] = lu_q3.data;
  end

  always_comb begin
    cl_wr.cl_addr = lu_q3.cl_addr;       // victim way for fill, hit way otherwise
    cl_wr.valid   = lu_q3.valid &&
                    ((lu_q3.op == FILL_LU) || ((lu_q3.op == WR_LU) && lu_q3.hit));
    cl_wr.line    = (lu_q3.op == FILL_LU) ? lu_q3.cl_data : merged;
  end

  // ====================
  // q4 register
  // ====================
  always_ff @(posedge clk) begin
    cl_wr_q4.cl_addr <= cl_wr.cl_addr;
    cl_wr_q4.line    <= cl_wr.line;
    if (reset) begin
      cl_wr_q4.valid <= 1'b0;
    end else begin
      cl_wr_q4.valid <= cl_wr.valid;
    end
  end

endmodule

//--- lookup_ctrl.sv
`timescale 1ns/1ps
/* lookup_ctrl: q1..q3 pipe registers, set hazard forwarding,
   data array read address, lookup response and far memory request */

module lookup_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::lu_req_t    lu_req,
  output cache_pkg::set_idx_t   set_rd_addr,
  input  cache_pkg::set_state_t set_rd,       // tag array read, q2
  output cache_pkg::pipe_bus_t  lu_q2,
  output cache_pkg::set_state_t set_q2,
  input  cache_pkg::way_res_t   res,
  output logic                  set_wr_en,
  output cache_pkg::set_idx_t   set_wr_addr,
  output cache_pkg::set_state_t set_wr,
  output cache_pkg::cl_addr_t   cl_rd_addr,
  output cache_pkg::pipe_bus_t  lu_q3,
  input  cache_pkg::line_t      line_q3,      // forwarded data array line
  output cache_pkg::lu_rsp_t    lu_rsp,
  output cache_pkg::fm_req_t    fm_req
);
  import cache_pkg::*;

  pipe_bus_t  lu_q1;
  pipe_bus_t  bus_q2;      // q2 with lookup results filled in
  set_state_t set_wr_q3;   // last set write, for b2b same-set access
  logic       set_hazard;
  logic       evict_q3;
  logic       miss_req_q3;

  // ====================
  // q1
  // ====================
  always_comb begin
    lu_q1         = '0;
    lu_q1.valid   = lu_req.valid;
    lu_q1.op      = lu_req.op;
    lu_q1.tq_id   = lu_req.tq_id;
    lu_q1.tag     = lu_req.address[ADDR_W-1 -: TAG_W];
    lu_q1.set     = lu_req.address[OFFSET_W +: SET_W];
    lu_q1.offset  = lu_req.address[OFFSET_W-1:0];
    lu_q1.data    = lu_req.data;
    lu_q1.cl_data = lu_req.cl_data;
  end

  assign set_rd_addr = lu_q1.set;    // tag array read

  // ====================
  // q2
  // ====================
  // q3 wrote this set last cycle, ram read is stale
  assign set_hazard  = lu_q2.valid && lu_q3.valid && (lu_q2.set == lu_q3.set);
  assign set_q2      = set_hazard ? set_wr_q3 : set_rd;
  assign set_wr_en   = lu_q2.valid;
  assign set_wr_addr = lu_q2.set;
  assign set_wr      = res.next_set;

  always_comb begin
    bus_q2             = lu_q2;
    bus_q2.hit_vec     = res.hit_vec;
    bus_q2.hit         = |res.hit_vec;
    bus_q2.miss        = lu_q2.valid && !(|res.hit_vec);
    bus_q2.victim_vec  = res.victim_vec;
    bus_q2.victim_way  = res.victim_way;
    bus_q2.victim_tag  = res.victim_tag;
    bus_q2.dirty_evict = res.dirty_evict;
    bus_q2.cl_addr.set = lu_q2.set;
    bus_q2.cl_addr.way = (lu_q2.op == FILL_LU) ? res.victim_way : res.hit_way;
  end

  assign cl_rd_addr = bus_q2.cl_addr;   // data array read

  always_ff @(posedge clk) begin
    lu_q2     <= lu_q1;
    lu_q3     <= bus_q2;
    set_wr_q3 <= set_wr;
    if (reset) begin
      lu_q2.valid <= 1'b0;
      lu_q3.valid <= 1'b0;
    end
  end

  // ====================
  // q3
  // ====================
  always_comb begin
    lu_rsp         = '0;
    lu_rsp.valid   = lu_q3.valid;
    lu_rsp.op      = lu_q3.op;
    lu_rsp.tq_id   = lu_q3.tq_id;
    lu_rsp.address = {lu_q3.tag, lu_q3.set, lu_q3.offset};
    lu_rsp.result  = !lu_q3.valid           ? NO_RSP :
                     (lu_q3.op == FILL_LU)  ? FILL   :
                     lu_q3.hit              ? HIT    : MISS;
    if (lu_q3.op == FILL_LU) begin
      lu_rsp.cl_data = lu_q3.cl_data;
    end else if ((lu_q3.op == RD_LU) && lu_q3.hit) begin
      lu_rsp.cl_data = line_q3;                     // read hit data
    end
  end

  assign evict_q3    = lu_q3.valid && lu_q3.dirty_evict;   // only fills raise it
  assign miss_req_q3 = lu_q3.valid && lu_q3.miss && (lu_q3.op != FILL_LU);

  always_comb begin
    fm_req = '0;
    if (evict_q3) begin
      fm_req.valid   = 1'b1;
      fm_req.opcode  = DIRTY_EVICT_OP;
      fm_req.address = {lu_q3.victim_tag, lu_q3.set, offset_t'(0)};
      fm_req.tq_id   = lu_q3.tq_id;
      fm_req.data    = line_q3;                     // victim's old line
    end else if (miss_req_q3) begin
      fm_req.valid   = 1'b1;
      fm_req.opcode  = FILL_REQ_OP;
      fm_req.address = {lu_q3.tag, lu_q3.set, lu_q3.offset};
      fm_req.tq_id   = lu_q3.tq_id;
    end
  end

  // one far memory request per cycle
  a_one_fm_req: assert property (@(posedge clk) disable iff (reset)
    !(evict_q3 && miss_req_q3))
    else $error("lookup_ctrl: dirty evict and miss request together");

endmodule

//--- set_ram.sv
`timescale 1ns/1ps
/* set_ram: storage array, one read and one write port
   registered read, old data on a same-cycle collision */

module set_ram #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output entry_t                   rd_data,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  entry_t                   wr_data
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;               // all ways invalid after reset
      end
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];      // sees the pre-write value
      if (wr_en) begin
        mem[wr_addr] <= wr_data;
      end
    end
  end

  // ====================
  // checks
  // ====================
  // write address comes from the pipe, must be known whenever it is used
  a_wr_addr_known: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> !$isunknown(wr_addr))
    else $error("set_ram: write with unknown address");

endmodule

//--- way_select.sv
`timescale 1ns/1ps
/* way_select: q2 tag compare and hit encode,
   fill victim choice and the next set state */

module way_select (
  input  cache_pkg::pipe_bus_t  lu,      // q2 request
  input  cache_pkg::set_state_t set_in,  // set state after hazard mux
  output cache_pkg::way_res_t   res
);
  import cache_pkg::*;

  way_vec_t   hit_vec;
  way_vec_t   free_vec;
  way_vec_t   victim_vec;
  way_idx_t   hit_way;
  way_idx_t   victim_way;
  logic       hit;
  logic       is_fill;
  set_state_t nxt;

  // lowest set bit only
  function automatic way_vec_t first_way(way_vec_t v);
    return v & (~v + way_vec_t'(1));
  endfunction

  function automatic way_idx_t encode(way_vec_t v);
    way_idx_t idx;
    idx = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (v[w]) begin
        idx = way_idx_t'(w);
      end
    end
    return idx;
  endfunction

  // ====================
  // tag compare
  // ====================
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = lu.valid && set_in.valid[w] && (set_in.tags[w] == lu.tag);
    end
  end

  assign hit      = |hit_vec;
  assign hit_way  = encode(hit_vec);
  assign is_fill  = lu.valid && (lu.op == FILL_LU);
  assign free_vec = ~set_in.valid;

  // ====================
  // victim, fill only
  // ====================
  always_comb begin
    victim_vec = '0;
    if (is_fill) begin
      // first free way, else first non-mru (bit flip keeps one free)
      victim_vec = (|free_vec) ? first_way(free_vec) : first_way(~set_in.mru);
    end
  end

  assign victim_way = encode(victim_vec);

  // next set state
  always_comb begin
    nxt = set_in;                                 // default keep the set
    if (hit && (lu.op == RD_LU)) begin
      nxt.mru = set_in.mru | hit_vec;
    end
    if (hit && (lu.op == WR_LU)) begin
      nxt.mru      = set_in.mru | hit_vec;
      nxt.modified = set_in.modified | hit_vec;   // line now dirty
    end
    if (is_fill) begin
      nxt.mru              = set_in.mru | victim_vec;
      nxt.valid            = set_in.valid | victim_vec;
      nxt.modified         = set_in.modified & ~victim_vec;  // fresh line is clean
      nxt.tags[victim_way] = lu.tag;
    end
    // all mru -> flip, keep only the way just touched
    if ((&nxt.mru) && (hit || is_fill)) begin
      nxt.mru = is_fill ? victim_vec : hit_vec;
    end
  end

  always_comb begin
    res.hit_vec     = hit_vec;
    res.hit_way     = hit_way;
    res.victim_vec  = victim_vec;
    res.victim_way  = victim_way;
    res.victim_tag  = set_in.tags[victim_way];    // old tag, for dirty evict
    res.dirty_evict = |(victim_vec & set_in.valid & set_in.modified);
    res.next_set    = nxt;
  end

  // ====================
  // checks
  // ====================
  always_comb begin
    if (lu.valid === 1'b1) begin
      // no duplicate tags may ever be stored in one set
      assert final ($onehot0(hit_vec))
        else $error("way_select: tag hit in more than one way");
      if (lu.op == FILL_LU) begin
        assert final ($onehot(victim_vec))
          else $error("way_select: fill without a single victim way");
      end
    end
  end

endmodule
